// File: rtl/l2_tlb_macros.svh
// Size constants shared by the L2 TLB RTL and its testbench, included where a width is needed
`ifndef L2_TLB_MACROS_SVH
`define L2_TLB_MACROS_SVH

//////////////////////////////
// Address space
//////////////////////////////

`define TLB_VA_WIDTH        32  // Input (virtual) address
`define TLB_PA_WIDTH        40  // Output (physical) address
`define TLB_PAGE_BITS       12  // 4 kB pages

//////////////////////////////
// TLB organisation
//////////////////////////////

`define TLB_N_SETS          8   // Selected by the low bits of the page number
`define TLB_N_ROWS          4   // Rows searched per set, one per cycle
`define TLB_N_BANKS         2   // Tag banks compared in parallel

// Each row of a bank holds two entries, one on each RAM port.
// The page RAM holds one page number per tag entry of every bank.

//////////////////////////////
// Configuration write port
//////////////////////////////

`define TLB_CFG_DATA_WIDTH  64
`define TLB_CFG_ADDR_WIDTH  16  // Word address

`endif

// File: rtl/l2_tlb_pkg.sv
// Types shared by the L2 TLB blocks, imported by each module that names one of them
`include "l2_tlb_macros.svh"

package l2_tlb_pkg;

   //////////////////////////////
   // Address fields
   //////////////////////////////

   typedef logic [`TLB_VA_WIDTH-`TLB_PAGE_BITS-1:0] vpn_t;  // Virtual page number
   typedef logic [`TLB_PA_WIDTH-`TLB_PAGE_BITS-1:0] ppn_t;  // Physical page number

   typedef logic [$clog2(`TLB_N_SETS)-1:0]  set_idx_t;  // Low bits of the page number
   typedef logic [$clog2(`TLB_N_ROWS)-1:0]  row_idx_t;
   typedef logic [$clog2(`TLB_N_BANKS)-1:0] bank_idx_t;

   // Tag RAM address is {set, row, port}
   typedef logic [$bits(set_idx_t)+$bits(row_idx_t):0] tag_addr_t;

   // One page number per tag entry and bank
   typedef logic [$bits(tag_addr_t)+$bits(bank_idx_t)-1:0] pa_addr_t;

   //////////////////////////////
   // Tag entry
   //////////////////////////////

   // Page number in the low bits, flags above it
   typedef logic [$bits(vpn_t)+3:0] tag_entry_t;

   localparam int unsigned TAG_VALID_BIT = $bits(vpn_t);
   localparam int unsigned TAG_READ_BIT  = $bits(vpn_t) + 1;  // Read allowed
   localparam int unsigned TAG_WRITE_BIT = $bits(vpn_t) + 2;  // Write allowed
   localparam int unsigned TAG_COH_BIT   = $bits(vpn_t) + 3;  // Cache coherent page

   //////////////////////////////
   // State machines
   //////////////////////////////

   typedef enum logic [1:0] {SEARCH_IDLE, SEARCH_RUN, SEARCH_DONE} search_state_t;

   typedef enum logic [1:0] {OUT_IDLE, OUT_WAIT_WRITE, OUT_SEND} out_state_t;

endpackage

// File: rtl/tlb_if.sv
// Internal buses of the L2 TLB: configuration writes and the row lookup path between blocks
`include "l2_tlb_macros.svh"

// Decoded configuration writes, one strobe per target
interface tlb_cfg_if
   import l2_tlb_pkg::*;
();
   logic [`TLB_N_BANKS-1:0] tag_we;  // One strobe per tag bank
   tag_addr_t               tag_waddr;
   tag_entry_t              tag_wdata;
   logic                    pa_we;
   pa_addr_t                pa_waddr;
   ppn_t                    pa_wdata;

   modport cfg  (output tag_we, tag_waddr, tag_wdata, pa_we, pa_waddr, pa_wdata);
   modport bank (input  tag_we, tag_waddr, tag_wdata);
   modport pa   (input  pa_we, pa_waddr, pa_wdata);
   modport mon  (input  tag_we);  // Search pauses on tag writes

endinterface

// Row reads toward the tag banks and compare results back
interface tlb_lookup_if
   import l2_tlb_pkg::*;
();
   row_idx_t                  row;        // Row being read
   logic                      rd_en;
   vpn_t                      vpn;        // Latched request page
   logic                      rw;         // 1 for a write request
   logic                      res_valid;  // Bank outputs belong to a read
   logic [`TLB_PAGE_BITS-1:0] page_off;   // Latched page offset

   // One bit per bank
   logic [`TLB_N_BANKS-1:0] hit;
   logic [`TLB_N_BANKS-1:0] prot;
   logic [`TLB_N_BANKS-1:0] coherent;
   logic [`TLB_N_BANKS-1:0] hit_port;  // Entry that hit, 0 or 1

   logic any_hit;

   modport ctrl (output row, rd_en, vpn, rw, res_valid, page_off, input any_hit);
   modport bank (input row, rd_en, vpn, rw, output hit, prot, coherent, hit_port);
   modport res  (input row, vpn, res_valid, page_off, hit, prot, coherent, hit_port,
                 output any_hit);

endinterface

// File: rtl/tlb_cfg_decode.sv
// Splits configuration word writes into tag-bank and page-RAM write strobes for the L2 TLB
`include "l2_tlb_macros.svh"

module tlb_cfg_decode
   import l2_tlb_pkg::*;
(
   input  logic                           clk_i,
   input  logic                           rst_ni,
   input  logic                           we_i,
   input  logic [`TLB_CFG_ADDR_WIDTH-1:0] waddr_i,
   input  logic [`TLB_CFG_DATA_WIDTH-1:0] wdata_i,
   tlb_cfg_if.cfg                         cfg_o
);

   localparam int unsigned BANK_BITS = $bits(bank_idx_t);
   localparam int unsigned SEL_BIT   = BANK_BITS + $bits(tag_addr_t);  // 0 tag, 1 page RAM

   logic      pa_sel;
   bank_idx_t wr_bank;

   assign pa_sel  = waddr_i[SEL_BIT];
   assign wr_bank = waddr_i[BANK_BITS-1:0];  // Bank in the lowest address bits

   always_comb begin
      for (int b = 0; b < `TLB_N_BANKS; b++) begin
         cfg_o.tag_we[b] = we_i & ~pa_sel & (wr_bank == bank_idx_t'(b));
      end
   end

   assign cfg_o.tag_waddr = waddr_i[SEL_BIT-1:BANK_BITS];  // {set, row, port}
   assign cfg_o.tag_wdata = wdata_i[$bits(tag_entry_t)-1:0];

   // Page RAM address is tag address times bank count plus bank
   assign cfg_o.pa_we    = we_i & pa_sel;
   assign cfg_o.pa_waddr = waddr_i[$bits(pa_addr_t)-1:0];
   assign cfg_o.pa_wdata = wdata_i[$bits(ppn_t)-1:0];

endmodule

// File: rtl/tlb_tag_bank.sv
// One virtual-tag RAM bank of the L2 TLB, reading a row per cycle and comparing both entries
module tlb_tag_bank
   import l2_tlb_pkg::*;
#(
   parameter int unsigned BANK_ID = 0
) (
   input  logic        clk_i,
   input  logic        rst_ni,
   tlb_cfg_if.bank     cfg_i,
   tlb_lookup_if.bank  lk_io
);

   localparam int unsigned TAG_DEPTH = 2 ** $bits(tag_addr_t);

   tag_entry_t tag_mem [TAG_DEPTH];
   tag_entry_t rd_q    [2];         // Entry 0 from port 0, entry 1 from port 1
   logic       rd_valid_q;
   logic       we;
   set_idx_t   set;
   tag_addr_t  addr0;
   tag_addr_t  addr1;
   logic [1:0] match;
   logic [1:0] allow;

   assign we    = cfg_i.tag_we[BANK_ID];
   assign set   = lk_io.vpn[$bits(set_idx_t)-1:0];
   assign addr0 = we ? cfg_i.tag_waddr : {set, lk_io.row, 1'b0};  // Port 0 shared with writes
   assign addr1 = {set, lk_io.row, 1'b1};

   //////////////////////////////
   // Two-port tag RAM
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (we) begin
         tag_mem[addr0] <= cfg_i.tag_wdata;
      end else if (lk_io.rd_en) begin
         rd_q[0] <= tag_mem[addr0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (lk_io.rd_en) begin
         rd_q[1] <= tag_mem[addr1];
      end
   end

   // Read data is fresh only in the cycle after a read
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= lk_io.rd_en;
      end
   end

   //////////////////////////////
   // Compare
   //////////////////////////////

   always_comb begin
      for (int e = 0; e < 2; e++) begin
         match[e] = rd_q[e][TAG_VALID_BIT] && (vpn_t'(rd_q[e]) == lk_io.vpn);
         allow[e] = lk_io.rw ? rd_q[e][TAG_WRITE_BIT] : rd_q[e][TAG_READ_BIT];
      end
   end

   // Entry 0 wins when both match
   assign lk_io.hit[BANK_ID]      = rd_valid_q & (|match);
   assign lk_io.hit_port[BANK_ID] = ~match[0];
   assign lk_io.prot[BANK_ID]     = rd_valid_q & (match[0] ? ~allow[0] : (match[1] & ~allow[1]));
   assign lk_io.coherent[BANK_ID] = match[0] ? rd_q[0][TAG_COH_BIT] : rd_q[1][TAG_COH_BIT];

endmodule

// File: rtl/tlb_search_ctrl.sv
// Lookup sequencer of the L2 TLB: latches the request and steps through the rows of its set
`include "l2_tlb_macros.svh"

module tlb_search_ctrl
   import l2_tlb_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  logic                     start_i,
   input  logic [`TLB_VA_WIDTH-1:0] addr_i,
   input  logic                     rw_i,
   output logic                     busy_o,
   tlb_cfg_if.mon                   cfg_i,
   tlb_lookup_if.ctrl               lk_o,
   output logic                     search_done_o,
   input  logic                     out_taken_i
);

   localparam row_idx_t LAST_ROW = row_idx_t'(`TLB_N_ROWS - 1);

   search_state_t             state_q;
   search_state_t             state_d;
   logic                      start_acc;
   logic                      rd_en;
   logic                      res_valid_q;
   logic                      all_rd_q;   // Last row has been read
   row_idx_t                  row_q;
   vpn_t                      vpn_q;
   logic                      rw_q;
   logic [`TLB_PAGE_BITS-1:0] off_q;

   assign start_acc = (state_q == SEARCH_IDLE) & start_i;
   assign busy_o    = (state_q != SEARCH_IDLE);

   // Stop on the first hit or on the result of the last row
   assign search_done_o = (state_q == SEARCH_RUN) & res_valid_q & (lk_o.any_hit | all_rd_q);

   // Tag writes own RAM port 0, so the row is held
   assign rd_en = (state_q == SEARCH_RUN) & ~all_rd_q & ~(|cfg_i.tag_we) & ~search_done_o;

   //////////////////////////////
   // FSM
   //////////////////////////////

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         SEARCH_IDLE: begin
            if (start_i) state_d = SEARCH_RUN;
         end
         SEARCH_RUN: begin
            if (search_done_o) state_d = SEARCH_DONE;
         end
         SEARCH_DONE: begin
            if (out_taken_i) state_d = SEARCH_IDLE;  // Result delivered
         end
         default: state_d = SEARCH_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q     <= SEARCH_IDLE;
         res_valid_q <= 1'b0;
         row_q       <= '0;
         all_rd_q    <= 1'b0;
      end else begin
         state_q     <= state_d;
         res_valid_q <= rd_en;  // One-cycle tag RAM latency
         if (start_acc) begin
            row_q    <= '0;
            all_rd_q <= 1'b0;
         end else if (rd_en) begin
            row_q <= row_q + 1'b1;
            if (row_q == LAST_ROW) all_rd_q <= 1'b1;
         end
      end
   end

   // Request is held so the caller may move on
   always_ff @(posedge clk_i) begin
      if (start_acc) begin
         vpn_q <= addr_i[`TLB_VA_WIDTH-1:`TLB_PAGE_BITS];
         off_q <= addr_i[`TLB_PAGE_BITS-1:0];
         rw_q  <= rw_i;
      end
   end

   assign lk_o.row       = row_q;
   assign lk_o.rd_en     = rd_en;
   assign lk_o.vpn       = vpn_q;
   assign lk_o.rw        = rw_q;
   assign lk_o.res_valid = res_valid_q;
   assign lk_o.page_off  = off_q;

endmodule

// File: rtl/tlb_result_ctrl.sv
// Result path of the L2 TLB: picks the hitting bank, reads the page RAM and holds the outputs
`include "l2_tlb_macros.svh"

module tlb_result_ctrl
   import l2_tlb_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_ni,
   tlb_lookup_if.res                lk_i,
   tlb_cfg_if.pa                    cfg_i,
   input  logic                     search_done_i,
   output logic                     out_taken_o,
   input  logic                     out_ready_i,
   output logic                     out_valid_o,
   output logic                     hit_o,
   output logic                     miss_o,
   output logic                     prot_o,
   output logic                     coherent_o,
   output logic [`TLB_PA_WIDTH-1:0] out_addr_o
);

   localparam int unsigned PA_DEPTH = 2 ** $bits(pa_addr_t);

   out_state_t state_q;
   out_state_t state_d;
   bank_idx_t  hit_bank;
   row_idx_t   res_row;
   tag_addr_t  hit_taddr;
   pa_addr_t   pa_raddr_new;
   pa_addr_t   pa_raddr_q;   // Kept for a read after a colliding write
   pa_addr_t   pa_raddr;
   logic       pa_rd;
   logic       load_raddr;
   logic       hit_d;
   logic       miss_d;
   logic       prot_d;
   logic       coh_d;
   ppn_t       pa_mem [PA_DEPTH];
   ppn_t       ppn_q;

   assign lk_i.any_hit = lk_i.res_valid & (|lk_i.hit);

   //////////////////////////////
   // Hit selection
   //////////////////////////////

   always_comb begin
      hit_bank = '0;
      for (int b = `TLB_N_BANKS - 1; b >= 0; b--) begin
         if (lk_i.hit[b]) hit_bank = bank_idx_t'(b);  // Lowest bank wins
      end
   end

   // Row has already advanced past the returning read
   assign res_row      = lk_i.row - 1'b1;
   assign hit_taddr    = {lk_i.vpn[$bits(set_idx_t)-1:0], res_row, lk_i.hit_port[hit_bank]};
   assign pa_raddr_new = pa_addr_t'(hit_taddr * `TLB_N_BANKS + hit_bank);

   //////////////////////////////
   // Output FSM
   //////////////////////////////

   always_comb begin
      state_d     = state_q;
      hit_d       = hit_o;
      miss_d      = miss_o;
      prot_d      = prot_o;
      coh_d       = coherent_o;
      pa_raddr    = pa_raddr_q;
      pa_rd       = 1'b0;
      load_raddr  = 1'b0;
      out_valid_o = 1'b0;
      out_taken_o = 1'b0;
      unique case (state_q)
         OUT_IDLE: begin
            if (search_done_i) begin
               state_d = OUT_SEND;
               hit_d   = lk_i.any_hit;
               miss_d  = ~lk_i.any_hit;
               prot_d  = lk_i.any_hit & lk_i.prot[hit_bank];
               coh_d   = 1'b0;
               if (lk_i.any_hit && !lk_i.prot[hit_bank]) begin
                  coh_d      = lk_i.coherent[hit_bank];
                  pa_raddr   = pa_raddr_new;
                  load_raddr = 1'b1;
                  if (cfg_i.pa_we) begin
                     state_d = OUT_WAIT_WRITE;  // RAM port busy with a write
                  end else begin
                     pa_rd = 1'b1;
                  end
               end
            end
         end
         OUT_WAIT_WRITE: begin
            if (!cfg_i.pa_we) begin
               pa_rd   = 1'b1;
               state_d = OUT_SEND;
            end
         end
         OUT_SEND: begin
            out_valid_o = 1'b1;
            if (out_ready_i) begin
               out_taken_o = 1'b1;
               state_d     = OUT_IDLE;
               hit_d       = 1'b0;
               miss_d      = 1'b0;
               prot_d      = 1'b0;
               coh_d       = 1'b0;
            end
         end
         default: state_d = OUT_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q    <= OUT_IDLE;
         hit_o      <= 1'b0;
         miss_o     <= 1'b0;
         prot_o     <= 1'b0;
         coherent_o <= 1'b0;
      end else begin
         state_q    <= state_d;
         hit_o      <= hit_d;
         miss_o     <= miss_d;
         prot_o     <= prot_d;
         coherent_o <= coh_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load_raddr) pa_raddr_q <= pa_raddr_new;
   end

   //////////////////////////////
   // Page RAM
   //////////////////////////////

   // Read register only loads on a read, so it holds while outputs wait
   always_ff @(posedge clk_i) begin
      if (cfg_i.pa_we) begin
         pa_mem[cfg_i.pa_waddr] <= cfg_i.pa_wdata;
      end else if (pa_rd) begin
         ppn_q <= pa_mem[pa_raddr];
      end
   end

   assign out_addr_o = {ppn_q, lk_i.page_off};

endmodule

// File: rtl/l2_tlb.sv
// Top level of the set-associative L2 TLB, connecting the configuration, tag, search and result blocks
`include "l2_tlb_macros.svh"

module l2_tlb (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   // Configuration writes
   input  logic                           we_i,
   input  logic [`TLB_CFG_ADDR_WIDTH-1:0] waddr_i,
   input  logic [`TLB_CFG_DATA_WIDTH-1:0] wdata_i,
   // Lookup request
   input  logic                           start_i,
   input  logic [`TLB_VA_WIDTH-1:0]       addr_i,
   input  logic                           rw_i,       // 1 for write
   output logic                           busy_o,
   // Result
   input  logic                           out_ready_i,
   output logic                           out_valid_o,
   output logic                           hit_o,
   output logic                           miss_o,
   output logic                           prot_o,
   output logic                           coherent_o,
   output logic [`TLB_PA_WIDTH-1:0]       out_addr_o
);

   logic search_done;
   logic out_taken;

   tlb_cfg_if    cfg_bus ();
   tlb_lookup_if lk_bus ();

   tlb_cfg_decode i_cfg_decode (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .we_i    (we_i),
      .waddr_i (waddr_i),
      .wdata_i (wdata_i),
      .cfg_o   (cfg_bus)
   );

   for (genvar b = 0; b < `TLB_N_BANKS; b++) begin : g_bank
      tlb_tag_bank #(
         .BANK_ID (b)
      ) i_tag_bank (
         .clk_i  (clk_i),
         .rst_ni (rst_ni),
         .cfg_i  (cfg_bus),
         .lk_io  (lk_bus)
      );
   end

   tlb_search_ctrl i_search_ctrl (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .start_i       (start_i),
      .addr_i        (addr_i),
      .rw_i          (rw_i),
      .busy_o        (busy_o),
      .cfg_i         (cfg_bus),
      .lk_o          (lk_bus),
      .search_done_o (search_done),
      .out_taken_i   (out_taken)
   );

   tlb_result_ctrl i_result_ctrl (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .lk_i          (lk_bus),
      .cfg_i         (cfg_bus),
      .search_done_i (search_done),
      .out_taken_o   (out_taken),
      .out_ready_i   (out_ready_i),
      .out_valid_o   (out_valid_o),
      .hit_o         (hit_o),
      .miss_o        (miss_o),
      .prot_o        (prot_o),
      .coherent_o    (coherent_o),
      .out_addr_o    (out_addr_o)
   );

endmodule

// File: sim/l2_tlb_assertions.sv
// Concurrent checks on the L2 TLB result handshake and reset values, bound into the top level
`include "l2_tlb_macros.svh"

module l2_tlb_assertions (
   input logic                     clk_i,
   input logic                     rst_ni,
   input logic                     busy_o,
   input logic                     out_ready_i,
   input logic                     out_valid_o,
   input logic                     hit_o,
   input logic                     miss_o,
   input logic                     prot_o,
   input logic                     coherent_o,
   input logic [`TLB_PA_WIDTH-1:0] out_addr_o
);

   int unsigned fail_cnt;

   initial fail_cnt = 0;

   // Result is held until the consumer takes it
   property p_hold_result;
      @(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(hit_o) && $stable(miss_o)
         && $stable(prot_o) && $stable(coherent_o) && $stable(out_addr_o);
   endproperty

   property p_reset_values;
      @(posedge clk_i)
      !rst_ni |=> !out_valid_o && !busy_o && !hit_o && !miss_o && !prot_o && !coherent_o;
   endproperty

   a_hold_result: assert property (p_hold_result) else begin
      $error("Result outputs changed while held under back-pressure");
      fail_cnt++;
   end

   a_reset_values: assert property (p_reset_values) else begin
      $error("Status or result outputs high after reset");
      fail_cnt++;
   end

endmodule

bind l2_tlb l2_tlb_assertions i_assertions (
   .clk_i       (clk_i),
   .rst_ni      (rst_ni),
   .busy_o      (busy_o),
   .out_ready_i (out_ready_i),
   .out_valid_o (out_valid_o),
   .hit_o       (hit_o),
   .miss_o      (miss_o),
   .prot_o      (prot_o),
   .coherent_o  (coherent_o),
   .out_addr_o  (out_addr_o)
);

// File: sim/tb_l2_tlb.sv
// Top testbench of the L2 TLB that fills its tables at random and checks lookups against a model
`include "l2_tlb_macros.svh"

module tb_l2_tlb
   import l2_tlb_pkg::*;
();

   localparam int unsigned CLK_PERIOD     = 40;
   localparam int unsigned RESET_CYCLES   = 8;
   localparam int unsigned SEED           = 32'h3a25b2aa;
   localparam int unsigned TAG_DEPTH      = 2 ** $bits(tag_addr_t);
   localparam int unsigned PA_DEPTH       = 2 ** $bits(pa_addr_t);
   localparam int unsigned SET_ENTRIES    = `TLB_N_ROWS * 2;  // Tag addresses per set
   localparam int unsigned SEL_BIT        = $bits(pa_addr_t);  // Selects the page RAM
   localparam int unsigned N_RANDOM       = 150;
   localparam int unsigned N_UPDATE       = 30;
   localparam int unsigned FILL_CYCLES    = `TLB_N_BANKS * TAG_DEPTH + PA_DEPTH + N_UPDATE + 4;
   localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + FILL_CYCLES + 20 * (N_RANDOM + N_UPDATE);

   logic                           clk_i;
   logic                           rst_ni;
   logic                           we_i;
   logic [`TLB_CFG_ADDR_WIDTH-1:0] waddr_i;
   logic [`TLB_CFG_DATA_WIDTH-1:0] wdata_i;
   logic                           start_i;
   logic [`TLB_VA_WIDTH-1:0]       addr_i;
   logic                           rw_i;
   logic                           busy_o;
   logic                           out_ready_i;
   logic                           out_valid_o;
   logic                           hit_o;
   logic                           miss_o;
   logic                           prot_o;
   logic                           coherent_o;
   logic [`TLB_PA_WIDTH-1:0]       out_addr_o;

   tag_entry_t  tag_model [`TLB_N_BANKS][TAG_DEPTH];  // Mirror of the tag banks
   ppn_t        ppn_model [PA_DEPTH];
   int unsigned n_hit;
   int unsigned n_prot;
   int unsigned n_miss;

   l2_tlb i_dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   //////////////////////////////
   // Model and stimulus helpers
   //////////////////////////////

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("** FAIL **");
         $fatal(1, "Stopped at the first error");
      end
   endtask

   function automatic pa_addr_t pa_index(input bank_idx_t bank, input tag_addr_t taddr);
      return pa_addr_t'(taddr * `TLB_N_BANKS + bank);
   endfunction

   // Small pool of page numbers so that lookups hit often
   function automatic vpn_t rand_vpn(input set_idx_t set, input int unsigned pool);
      return vpn_t'((($urandom % pool) << $bits(set_idx_t)) | set);
   endfunction

   function automatic tag_entry_t rand_entry(input set_idx_t set);
      tag_entry_t e;
      e = tag_entry_t'(rand_vpn(set, 8));
      e[TAG_VALID_BIT] = ($urandom % 5) != 0;
      e[TAG_READ_BIT]  = ($urandom % 4) != 0;
      e[TAG_WRITE_BIT] = ($urandom % 2) == 1;
      e[TAG_COH_BIT]   = ($urandom % 2) == 1;
      return e;
   endfunction

   function automatic ppn_t rand_ppn(input pa_addr_t paddr);
      ppn_t p;
      p = ppn_t'($urandom);
      p[$bits(pa_addr_t)-1:0] = paddr;  // Low bits keep page numbers unique
      return p;
   endfunction

   // One write cycle that starts and ends at a falling edge
   task automatic cfg_write(input int unsigned addr, input logic [`TLB_CFG_DATA_WIDTH-1:0] data);
      we_i    = 1'b1;
      waddr_i = addr;
      wdata_i = data;
      @(negedge clk_i);
      we_i    = 1'b0;
   endtask

   task automatic write_tag(input bank_idx_t bank, input tag_addr_t taddr, input tag_entry_t e);
      tag_model[bank][taddr] = e;
      cfg_write((taddr << $bits(bank_idx_t)) | bank, e);
   endtask

   task automatic write_ppn(input pa_addr_t paddr, input ppn_t ppn);
      ppn_model[paddr] = ppn;
      cfg_write((1 << SEL_BIT) | paddr, ppn);
   endtask

   // Write to a set other than the one being searched
   task automatic disturb_write(input set_idx_t busy_set);
      set_idx_t  other;
      tag_addr_t taddr;
      bank_idx_t bank;
      other = set_idx_t'(busy_set + 1 + $urandom % (`TLB_N_SETS - 1));
      taddr = tag_addr_t'(other * SET_ENTRIES + $urandom % SET_ENTRIES);
      bank  = bank_idx_t'($urandom % `TLB_N_BANKS);
      if ($urandom % 2 == 0) begin
         write_tag(bank, taddr, rand_entry(other));  // Pauses the search
      end else begin
         write_ppn(pa_index(bank, taddr), rand_ppn(pa_index(bank, taddr)));
      end
   endtask

   // Rows in order, then banks low to high, then port 0 before port 1
   task automatic predict(input logic [`TLB_VA_WIDTH-1:0] addr, input logic rw,
                          output logic hit, output logic prot, output logic coh,
                          output logic [`TLB_PA_WIDTH-1:0] pa);
      vpn_t       vpn;
      set_idx_t   set;
      tag_addr_t  taddr;
      tag_entry_t e;
      vpn  = addr[`TLB_VA_WIDTH-1:`TLB_PAGE_BITS];
      set  = vpn[$bits(set_idx_t)-1:0];
      hit  = 1'b0;
      prot = 1'b0;
      coh  = 1'b0;
      pa   = '0;
      for (int row = 0; row < `TLB_N_ROWS; row++) begin
         for (int b = 0; b < `TLB_N_BANKS; b++) begin
            for (int port = 0; port < 2; port++) begin
               taddr = tag_addr_t'(set * SET_ENTRIES + row * 2 + port);
               e     = tag_model[b][taddr];
               if (!hit && e[TAG_VALID_BIT] && e[$bits(vpn_t)-1:0] == vpn) begin
                  hit  = 1'b1;
                  prot = rw ? !e[TAG_WRITE_BIT] : !e[TAG_READ_BIT];
                  coh  = e[TAG_COH_BIT];
                  pa   = {ppn_model[pa_index(bank_idx_t'(b), taddr)],
                          addr[`TLB_PAGE_BITS-1:0]};
               end
            end
         end
      end
   endtask

   function automatic logic [`TLB_VA_WIDTH-1:0] pick_addr();
      vpn_t                      vpn;
      logic [`TLB_PAGE_BITS-1:0] off;
      off = $urandom;
      if ($urandom % 4 != 0) begin
         vpn = tag_model[$urandom % `TLB_N_BANKS][$urandom % TAG_DEPTH][$bits(vpn_t)-1:0];
      end else begin
         vpn = rand_vpn(set_idx_t'($urandom), 12);  // Often no match
      end
      return {vpn, off};
   endfunction

   //////////////////////////////
   // Lookup with checks
   //////////////////////////////

   task automatic run_lookup(input logic [`TLB_VA_WIDTH-1:0] addr, input logic rw,
                             input logic disturb);
      logic                     exp_hit;
      logic                     exp_prot;
      logic                     exp_coh;
      logic [`TLB_PA_WIDTH-1:0] exp_pa;
      logic [`TLB_PA_WIDTH-1:0] held_pa;
      logic [3:0]               held_flags;
      set_idx_t                 busy_set;
      busy_set = addr[`TLB_PAGE_BITS +: $bits(set_idx_t)];
      predict(addr, rw, exp_hit, exp_prot, exp_coh, exp_pa);
      check_value("busy_o", busy_o, 1'b0);
      start_i = 1'b1;
      addr_i  = addr;
      rw_i    = rw;
      @(negedge clk_i);
      start_i = 1'b0;
      addr_i  = $urandom;  // Request was latched at start
      rw_i    = !rw;
      while (!out_valid_o) begin
         check_value("busy_o", busy_o, 1'b1);
         if (disturb && ($urandom % 4 == 0)) begin
            disturb_write(busy_set);
         end else begin
            @(negedge clk_i);
         end
      end
      check_value("hit_o", hit_o, exp_hit);
      check_value("miss_o", miss_o, !exp_hit);
      check_value("prot_o", prot_o, exp_prot);
      if (exp_hit && !exp_prot) begin
         check_value("coherent_o", coherent_o, exp_coh);
         check_value("out_addr_o", out_addr_o, exp_pa);
      end
      held_flags = {hit_o, miss_o, prot_o, coherent_o};
      held_pa    = out_addr_o;
      repeat ($urandom % 4) begin  // Back-pressure
         @(negedge clk_i);
         check_value("out_valid_o", out_valid_o, 1'b1);
         check_value("busy_o", busy_o, 1'b1);
         check_value("{hit_o,miss_o,prot_o,coherent_o}", {hit_o, miss_o, prot_o, coherent_o},
                     held_flags);
         check_value("out_addr_o", out_addr_o, held_pa);
      end
      out_ready_i = 1'b1;
      @(negedge clk_i);
      out_ready_i = 1'b0;
      check_value("out_valid_o", out_valid_o, 1'b0);
      check_value("busy_o", busy_o, 1'b0);
      @(negedge clk_i);
      check_value("out_valid_o", out_valid_o, 1'b0);  // One result per start
      if (!exp_hit) n_miss++;
      else if (exp_prot) n_prot++;
      else n_hit++;
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      int unsigned              seed_ret;
      bank_idx_t                bank;
      tag_addr_t                taddr;
      pa_addr_t                 paddr;
      tag_entry_t               entry;
      logic [`TLB_PAGE_BITS-1:0] off;
      seed_ret    = $urandom(SEED);
      rst_ni      = 1'b0;
      we_i        = 1'b0;
      waddr_i     = '0;
      wdata_i     = '0;
      start_i     = 1'b0;
      addr_i      = '0;
      rw_i        = 1'b0;
      out_ready_i = 1'b0;
      n_hit       = 0;
      n_prot      = 0;
      n_miss      = 0;
      repeat (RESET_CYCLES) @(negedge clk_i);
      rst_ni = 1'b1;

      // Every entry is written so no lookup reads unknown RAM contents
      for (int b = 0; b < `TLB_N_BANKS; b++) begin
         for (int t = 0; t < TAG_DEPTH; t++) begin
            write_tag(bank_idx_t'(b), tag_addr_t'(t), rand_entry(set_idx_t'(t / SET_ENTRIES)));
         end
      end
      for (int p = 0; p < PA_DEPTH; p++) begin
         write_ppn(pa_addr_t'(p), rand_ppn(pa_addr_t'(p)));
      end

      repeat (N_RANDOM) begin
         run_lookup(pick_addr(), $urandom % 2 == 1, 1'b1);
      end

      // Changed entries must change the next lookup of their page
      repeat (N_UPDATE) begin
         bank  = bank_idx_t'($urandom % `TLB_N_BANKS);
         taddr = tag_addr_t'($urandom % TAG_DEPTH);
         paddr = pa_index(bank, taddr);
         entry = tag_model[bank][taddr];
         off   = $urandom;
         if ($urandom % 2 == 0) begin
            write_ppn(paddr, rand_ppn(paddr));
         end else begin
            entry[TAG_VALID_BIT] = 1'b0;
            write_tag(bank, taddr, entry);
         end
         run_lookup({entry[$bits(vpn_t)-1:0], off}, $urandom % 2 == 1, 1'b0);
      end

      $display("Lookups checked: %0d hits, %0d faults, %0d misses", n_hit, n_prot, n_miss);
      $display("** PASS **");
      $finish;
   end

   // Bound checker counts its failures
   initial begin
      wait (i_dut.i_assertions.fail_cnt != 0);
      $display("A concurrent assertion on the DUT outputs failed");
      $display("** FAIL **");
      $fatal(1, "Assertion failure");
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk_i);
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $fatal(1, "Watchdog expired");
   end

endmodule

// File: tb.f
+incdir+rtl
rtl/l2_tlb_pkg.sv
rtl/tlb_if.sv
rtl/tlb_cfg_decode.sv
rtl/tlb_tag_bank.sv
rtl/tlb_search_ctrl.sv
rtl/tlb_result_ctrl.sv
rtl/l2_tlb.sv
sim/l2_tlb_assertions.sv
sim/tb_l2_tlb.sv
